// File: common/decodePkg.sv
// ====================================================================
// Decode package
// Shared instruction format, opcode and function code enums, and the
// decoded-record structs used by every decode lane
// ====================================================================

package decodePkg;

	// ================================================================
	// Major opcodes
	// ================================================================

	// Values not listed here are unassigned and decode as illegal
	typedef enum logic [6:0]
	{
		OP_SYS   = 7'd0,
		OP_R2    = 7'd2,
		// Immediate arithmetic and logic
		OP_ADDI  = 7'd4,
		OP_SUBFI = 7'd5,
		OP_CMPI  = 7'd6,
		OP_MULI  = 7'd7,
		OP_ANDI  = 7'd8,
		OP_ORI   = 7'd9,
		OP_EORI  = 7'd10,
		OP_SLTI  = 7'd11,
		OP_DIVI  = 7'd13,
		// Other ALU forms
		OP_SHIFT = 7'd16,
		OP_CSR   = 7'd17,
		OP_MOV   = 7'd18,
		// Conditional branches compare rs1 with rs2
		OP_BEQ   = 7'd24,
		OP_BNE   = 7'd25,
		OP_BLT   = 7'd26,
		OP_BGE   = 7'd27,
		// Subroutine calls
		OP_BSR   = 7'd32,
		OP_JSR   = 7'd33,
		// Loads, the U forms zero-extend the loaded value
		OP_LDB   = 7'd64,
		OP_LDBU  = 7'd65,
		OP_LDW   = 7'd66,
		OP_LDWU  = 7'd67,
		OP_LDT   = 7'd68,
		OP_LDTU  = 7'd69,
		OP_LDO   = 7'd70,
		// Stores take their data from rs2
		OP_STB   = 7'd80,
		OP_STW   = 7'd81,
		OP_STT   = 7'd82,
		OP_STO   = 7'd83,
		OP_FENCE = 7'd120,
		OP_NOP   = 7'd127
	} opcodeT;

	// ================================================================
	// Register-form function codes
	// ================================================================

	typedef enum logic [5:0]
	{
		FN_ADD  = 6'd4,
		FN_SUB  = 6'd5,
		FN_CMP  = 6'd6,
		FN_MUL  = 6'd7,
		FN_DIV  = 6'd8,
		FN_MULU = 6'd15,
		FN_DIVU = 6'd16,
		FN_AND  = 6'd20,
		FN_OR   = 6'd21,
		FN_EOR  = 6'd22,
		FN_ANDC = 6'd23,
		FN_NAND = 6'd24,
		FN_NOR  = 6'd25,
		FN_ENOR = 6'd26,
		FN_ORC  = 6'd27,
		FN_SEQ  = 6'd40,
		FN_SNE  = 6'd41,
		FN_SLT  = 6'd42,
		FN_SLE  = 6'd43,
		FN_SLTU = 6'd44,
		FN_SLEU = 6'd45
	} funcT;

	// Instruction word, top bit first
	// Outside the register form the 15 bits above rs1 are the immediate
	typedef struct packed
	{
		logic [3:0] spare;
		funcT       func;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [4:0] rd;
		opcodeT     opcode;
	} instrT;

	// ================================================================
	// Decoded record
	// ================================================================

	typedef enum logic [1:0]
	{
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} memSizeT;

	typedef struct packed
	{
		logic    isLoad;
		logic    isStore;
		logic    isUnsigned;
		memSizeT size;
	} memDecT;

	typedef enum logic [2:0]
	{
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_CALL = 3'd5
	} branchKindT;

	typedef struct packed
	{
		logic       readsRs1;
		logic       readsRs2;
		logic       writesRd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
	} regUseT;

	typedef struct packed
	{
		logic        isAlu;
		memDecT      mem;
		branchKindT  branch;
		regUseT      regs;
		logic [31:0] imm;
		logic        isIllegal;
		logic        isSys;
		opcodeT      opcode;
	} decodedT;

endpackage

// File: decode/decodeAlu.sv
// ====================================================================
// ALU classifier
// Flags instructions that go through the integer ALU and address path
// ====================================================================

`timescale 1ns/1ps

module decodeAlu
(
	input  decodePkg::instrT instr,
	output logic             alu
);

	import decodePkg::*;

	// One case on the opcode, with the register form split by function code
	always_comb
	begin
		case (instr.opcode)
			// System instructions are handled outside the ALU
			OP_SYS:
				alu = 1'b0;
			OP_R2:
				case (instr.func)
					FN_ADD, FN_SUB, FN_CMP:
						alu = 1'b1;
					FN_MUL, FN_MULU, FN_DIV, FN_DIVU:
						alu = 1'b1;
					FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_ORC:
						alu = 1'b1;
					FN_NAND, FN_NOR, FN_ENOR:
						alu = 1'b1;
					FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
						alu = 1'b1;
					// Unassigned function code
					default:
						alu = 1'b0;
				endcase
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI:
				alu = 1'b1;
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI:
				alu = 1'b1;
			OP_SHIFT, OP_CSR, OP_MOV:
				alu = 1'b1;
			// Loads and stores need the ALU to form their address
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
				alu = 1'b1;
			OP_STB, OP_STW, OP_STT, OP_STO:
				alu = 1'b1;
			OP_NOP, OP_FENCE:
				alu = 1'b1;
			// Calls compute the link value in the ALU
			OP_BSR, OP_JSR:
				alu = 1'b1;
			// Conditional branches go to the branch unit only
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE:
				alu = 1'b0;
			default:
				alu = 1'b0;
		endcase
	end

endmodule

// File: decode/decodeMem.sv
// ====================================================================
// Memory access classifier
// Marks loads and stores and gives the access size and signedness
// ====================================================================

`timescale 1ns/1ps

module decodeMem
(
	input  decodePkg::instrT  instr,
	output decodePkg::memDecT mem
);

	import decodePkg::*;

	always_comb
	begin
		// Anything that is not a load or store has no access
		mem = '0;
		case (instr.opcode)
			OP_LDB, OP_LDBU:
			begin
				mem.isLoad = 1'b1;
				mem.size = SZ_BYTE;
			end
			OP_LDW, OP_LDWU:
			begin
				mem.isLoad = 1'b1;
				mem.size = SZ_WYDE;
			end
			OP_LDT, OP_LDTU:
			begin
				mem.isLoad = 1'b1;
				mem.size = SZ_TETRA;
			end
			OP_LDO:
			begin
				mem.isLoad = 1'b1;
				mem.size = SZ_OCTA;
			end
			OP_STB:
			begin
				mem.isStore = 1'b1;
				mem.size = SZ_BYTE;
			end
			OP_STW:
			begin
				mem.isStore = 1'b1;
				mem.size = SZ_WYDE;
			end
			OP_STT:
			begin
				mem.isStore = 1'b1;
				mem.size = SZ_TETRA;
			end
			OP_STO:
			begin
				mem.isStore = 1'b1;
				mem.size = SZ_OCTA;
			end
			default:
				mem = '0;
		endcase

		// Only the narrow U loads zero-extend, an octa load fills the register
		mem.isUnsigned = (instr.opcode == OP_LDBU) || (instr.opcode == OP_LDWU) ||
			(instr.opcode == OP_LDTU);
	end

endmodule

// File: decode/decodeBranch.sv
// ====================================================================
// Branch classifier
// Maps conditional branches to their condition and calls to BR_CALL
// ====================================================================

`timescale 1ns/1ps

module decodeBranch
(
	input  decodePkg::instrT      instr,
	output decodePkg::branchKindT branch
);

	import decodePkg::*;

	always_comb
	begin
		case (instr.opcode)
			// Conditional forms compare rs1 against rs2
			OP_BEQ:
				branch = BR_EQ;
			OP_BNE:
				branch = BR_NE;
			OP_BLT:
				branch = BR_LT;
			OP_BGE:
				branch = BR_GE;
			// BSR is pc relative and JSR goes through rs1, both link to rd
			OP_BSR, OP_JSR:
				branch = BR_CALL;
			default:
				branch = BR_NONE;
		endcase
	end

endmodule

// File: decode/decodeRegs.sv
// ====================================================================
// Register usage decoder
// Works out which of rs1, rs2 and rd an instruction reads or writes
// ====================================================================

`timescale 1ns/1ps

module decodeRegs
(
	input  decodePkg::instrT  instr,
	output decodePkg::regUseT regs
);

	import decodePkg::*;

	// Destination use before the register zero check
	logic rdWrite;

	always_comb
	begin
		// Register numbers pass through as they are in the word
		regs.rs1 = instr.rs1;
		regs.rs2 = instr.rs2;
		regs.rd = instr.rd;

		// Almost every form reads rs1 as a source or base register
		case (instr.opcode)
			OP_NOP, OP_FENCE, OP_SYS, OP_BSR:
				regs.readsRs1 = 1'b0;
			default:
				regs.readsRs1 = 1'b1;
		endcase

		// Rs2 is a data register or second comparand only in these forms
		case (instr.opcode)
			OP_R2, OP_STB, OP_STW, OP_STT, OP_STO:
				regs.readsRs2 = 1'b1;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE:
				regs.readsRs2 = 1'b1;
			default:
				regs.readsRs2 = 1'b0;
		endcase

		case (instr.opcode)
			OP_R2, OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI:
				rdWrite = 1'b1;
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_SHIFT:
				rdWrite = 1'b1;
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
				rdWrite = 1'b1;
			// Calls write the return address into rd
			OP_MOV, OP_CSR, OP_BSR, OP_JSR:
				rdWrite = 1'b1;
			default:
				rdWrite = 1'b0;
		endcase

		// Register zero always reads as zero so a write to it is dropped
		regs.writesRd = rdWrite && (instr.rd != 5'd0);
	end

endmodule

// File: decode/decodeImm.sv
// ====================================================================
// Immediate decoder
// Extracts the 15-bit immediate and extends it to 32 bits by opcode
// ====================================================================

`timescale 1ns/1ps

module decodeImm
(
	input  decodePkg::instrT instr,
	output logic [31:0]      imm
);

	import decodePkg::*;

	// Immediate field sits in the 15 bits above rs1
	logic [14:0] immField;

	assign immField = {instr.spare, instr.func, instr.rs2};

	always_comb
	begin
		case (instr.opcode)
			// Register form and control forms carry no immediate
			OP_R2, OP_NOP, OP_FENCE, OP_SYS:
				imm = 32'd0;
			// Logic immediates are masks and so zero-extend
			OP_ANDI, OP_ORI, OP_EORI:
				imm = {17'd0, immField};
			// Displacements, branch offsets and arithmetic constants are signed
			default:
				imm = {{17{immField[14]}}, immField};
		endcase
	end

endmodule

// File: decode/decodeSlot.sv
// ====================================================================
// Decode lane
// Runs the field decoders on one instruction, flags illegal encodings
// and registers the decoded record with stall hold
// ====================================================================

`timescale 1ns/1ps

module decodeSlot
(
	input  logic               clk,
	input  logic               rstN,
	input  logic               stall,
	input  logic               instrValid,
	input  decodePkg::instrT   instr,
	output logic               decValid,
	output decodePkg::decodedT decoded
);

	import decodePkg::*;

	logic       alu;
	memDecT     mem;
	branchKindT branch;
	regUseT     regs;
	logic [31:0] imm;
	decodedT    record;

	// ================================================================
	// Field decoders, all combinational on the same word
	// ================================================================

	decodeAlu i_alu
	(
		.instr (instr),
		.alu   (alu)
	);

	decodeMem i_mem
	(
		.instr (instr),
		.mem   (mem)
	);

	decodeBranch i_branch
	(
		.instr  (instr),
		.branch (branch)
	);

	decodeRegs i_regs
	(
		.instr (instr),
		.regs  (regs)
	);

	decodeImm i_imm
	(
		.instr (instr),
		.imm   (imm)
	);

	// ================================================================
	// Record assembly and output register
	// ================================================================

	always_comb
	begin
		record.isAlu = alu;
		record.mem = mem;
		record.branch = branch;
		record.regs = regs;
		record.imm = imm;
		record.isSys = (instr.opcode == OP_SYS);
		// An instruction no unit claims is either an unassigned opcode
		// or a register form with an unassigned function code
		record.isIllegal = !(alu || (branch != BR_NONE) || record.isSys);
		record.opcode = instr.opcode;
	end

	// Upstream holds its inputs during stall, so holding here loses nothing
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			decValid <= 1'b0;
			decoded <= '0;
		end
		else if (!stall)
		begin
			decValid <= instrValid;
			decoded <= record;
		end
	end

endmodule

// File: rtl/decodeTop.sv
// ====================================================================
// Decode top level
// Builds numLanes independent decode lanes sharing clock, reset and stall
// ====================================================================

`timescale 1ns/1ps

module decodeTop
#(
	parameter int numLanes = 2
)
(
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 stall,
	input  logic [numLanes-1:0]  instrValid,
	input  decodePkg::instrT     instr [numLanes],
	output logic [numLanes-1:0]  decValid,
	output decodePkg::decodedT   decoded [numLanes]
);

	// Each lane decodes its own word, stall freezes all lanes together
	for (genvar lane = 0; lane < numLanes; lane++)
	begin : g_lane
		decodeSlot i_slot
		(
			.clk        (clk),
			.rstN       (rstN),
			.stall      (stall),
			.instrValid (instrValid[lane]),
			.instr      (instr[lane]),
			.decValid   (decValid[lane]),
			.decoded    (decoded[lane])
		);
	end

endmodule

// File: bench/decodeSlot_assert.sv
// ====================================================================
// Decode lane assertions
// Reset, stall hold and illegal flag properties on the lane register
// ====================================================================

`timescale 1ns/1ps

module decodeSlotAssert
(
	input logic               clk,
	input logic               rstN,
	input logic               stall,
	input logic               decValid,
	input decodePkg::decodedT decoded
);

	import decodePkg::*;

	// Number of assertion failures seen in this lane
	int failCount = 0;

	// No valid output may appear while reset is held
	assert property (@(posedge clk) !rstN |-> !decValid)
	else
	begin
		failCount++;
		$error("decValid high during reset");
	end

	// A stalled edge leaves both registers untouched
	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> ($stable(decoded) && $stable(decValid)))
	else
	begin
		failCount++;
		$error("Lane output changed across a stalled cycle");
	end

	// An instruction the ALU claims is never illegal
	assert property (@(posedge clk) disable iff (!rstN)
		!(decoded.isIllegal && decoded.isAlu))
	else
	begin
		failCount++;
		$error("isIllegal and isAlu both high");
	end

endmodule

bind decodeSlot decodeSlotAssert i_slotAssert
(
	.clk      (clk),
	.rstN     (rstN),
	.stall    (stall),
	.decValid (decValid),
	.decoded  (decoded)
);

// File: bench/decodeTb.sv
// ====================================================================
// Decode testbench
// Directed tests for the two-lane decode top level, checked against a
// reference decode model, with a watchdog on the total run time
// ====================================================================

`timescale 1ns/1ps

module decodeTb;

	import decodePkg::*;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 4;
	localparam int numOpcodes = 33;
	localparam int numFuncs = 21;
	localparam int randCount = 40;
	// Cycles spent by the tests below, in the order they run
	localparam int testCycles = resetCycles + 1 + 2 * (2 * numOpcodes + numFuncs + 1) +
		6 + 8 + 4 + randCount + 1;
	localparam int marginCycles = 50;

	logic        clk;
	logic        rstN;
	logic        stall;
	logic [1:0]  instrValid;
	instrT       instr [2];
	logic [1:0]  decValid;
	decodedT     decoded [2];

	int errorCount;
	int checkCount;
	int assertFails;
	int seed = 58076;

	decodeTop
	#(
		.numLanes (2)
	)
	i_decodeTop
	(
		.clk        (clk),
		.rstN       (rstN),
		.stall      (stall),
		.instrValid (instrValid),
		.instr      (instr),
		.decValid   (decValid),
		.decoded    (decoded)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ================================================================
	// Reference decode model
	// ================================================================

	function automatic logic isLoadOp(input opcodeT op);
		case (op)
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isStoreOp(input opcodeT op);
		return (op == OP_STB) || (op == OP_STW) || (op == OP_STT) || (op == OP_STO);
	endfunction

	function automatic logic isImmArithOp(input opcodeT op);
		case (op)
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_ANDI, OP_ORI, OP_EORI, OP_SLTI:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic funcAssigned(input funcT fn);
		case (fn)
			FN_ADD, FN_SUB, FN_CMP, FN_MUL, FN_MULU, FN_DIV, FN_DIVU:
				return 1'b1;
			FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR, FN_ENOR, FN_ANDC, FN_ORC:
				return 1'b1;
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Expected record for one word, built field by field from the raw bits
	function automatic decodedT decodeModel(input instrT w);
		logic [31:0] raw;
		opcodeT      op;
		logic        ld;
		logic        st;
		logic        call;
		decodedT     d;
		raw = w;
		op = w.opcode;
		ld = isLoadOp(op);
		st = isStoreOp(op);
		call = (op == OP_BSR) || (op == OP_JSR);
		d = '0;
		d.isAlu = ((op == OP_R2) && funcAssigned(w.func)) || isImmArithOp(op) ||
			(op == OP_SHIFT) || (op == OP_CSR) || (op == OP_MOV) || ld || st ||
			(op == OP_NOP) || (op == OP_FENCE) || call;
		d.mem.isLoad = ld;
		d.mem.isStore = st;
		d.mem.isUnsigned = (op == OP_LDBU) || (op == OP_LDWU) || (op == OP_LDTU);
		case (op)
			OP_LDB, OP_LDBU, OP_STB:
				d.mem.size = SZ_BYTE;
			OP_LDW, OP_LDWU, OP_STW:
				d.mem.size = SZ_WYDE;
			OP_LDT, OP_LDTU, OP_STT:
				d.mem.size = SZ_TETRA;
			OP_LDO, OP_STO:
				d.mem.size = SZ_OCTA;
			default:
				d.mem.size = SZ_BYTE;
		endcase
		case (op)
			OP_BEQ:
				d.branch = BR_EQ;
			OP_BNE:
				d.branch = BR_NE;
			OP_BLT:
				d.branch = BR_LT;
			OP_BGE:
				d.branch = BR_GE;
			OP_BSR, OP_JSR:
				d.branch = BR_CALL;
			default:
				d.branch = BR_NONE;
		endcase
		d.regs.rs1 = raw[16:12];
		d.regs.rs2 = raw[21:17];
		d.regs.rd = raw[11:7];
		d.regs.readsRs1 = !((op == OP_NOP) || (op == OP_FENCE) || (op == OP_SYS) ||
			(op == OP_BSR));
		d.regs.readsRs2 = (op == OP_R2) || st || (op == OP_BEQ) || (op == OP_BNE) ||
			(op == OP_BLT) || (op == OP_BGE);
		d.regs.writesRd = ((op == OP_R2) || isImmArithOp(op) || (op == OP_SHIFT) || ld ||
			(op == OP_MOV) || (op == OP_CSR) || call) && (raw[11:7] != 5'd0);
		// Logic immediates are masks, everything else with a field is signed
		if ((op == OP_R2) || (op == OP_NOP) || (op == OP_FENCE) || (op == OP_SYS))
			d.imm = 32'd0;
		else if ((op == OP_ANDI) || (op == OP_ORI) || (op == OP_EORI))
			d.imm = {17'd0, raw[31:17]};
		else
			d.imm = {{17{raw[31]}}, raw[31:17]};
		d.isSys = (op == OP_SYS);
		d.isIllegal = !(d.isAlu || (d.branch != BR_NONE) || d.isSys);
		d.opcode = op;
		return d;
	endfunction

	// Upper holds spare, func and rs2, which is the immediate outside OP_R2
	function automatic instrT makeWord(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [14:0] upper);
		logic [31:0] raw;
		raw = {upper, rs1, rd, op};
		return raw;
	endfunction

	// ================================================================
	// Checking and stimulus helpers
	// ================================================================

	task automatic check(input string name, input logic [95:0] expected,
		input logic [95:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Drives one word per lane, lets the DUT take it and checks both lanes
	task automatic applyPair(input string name, input instrT a, input instrT b,
		input logic [1:0] valid);
		decodedT expA;
		decodedT expB;
		expA = decodeModel(a);
		expB = decodeModel(b);
		@(posedge clk);
		instr[0] <= a;
		instr[1] <= b;
		instrValid <= valid;
		stall <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check({name, " decValid"}, valid, decValid);
		if (valid[0])
			check({name, " lane0"}, expA, decoded[0]);
		if (valid[1])
			check({name, " lane1"}, expB, decoded[1]);
	endtask

	// ================================================================
	// Directed tests
	// ================================================================

	task automatic resetTest();
		int c;
		@(posedge clk);
		instr[0] <= makeWord(OP_ADDI, 5'd1, 5'd2, 15'h1234);
		instr[1] <= makeWord(OP_LDO, 5'd3, 5'd4, 15'h0042);
		instrValid <= 2'b11;
		for (c = 0; c < resetCycles; c++)
		begin
			@(negedge clk);
			check("reset decValid", 2'b00, decValid);
			check("reset lane0", '0, decoded[0]);
			check("reset lane1", '0, decoded[1]);
		end
		@(posedge clk);
		rstN <= 1'b1;
		instrValid <= 2'b00;
		// The release edge itself still sees reset
		@(negedge clk);
		check("after reset decValid", 2'b00, decValid);
		check("after reset lane0", '0, decoded[0]);
	endtask

	task automatic aluTest();
		opcodeT op;
		funcT   fn;
		int     n;
		op = op.first();
		for (n = 0; n < op.num(); n++)
		begin
			applyPair($sformatf("alu %s", op.name()), makeWord(op, 5'd3, 5'd4, 15'h0123),
				makeWord(op, 5'd0, 5'd7, 15'h4567), 2'b11);
			op = op.next();
		end
		fn = fn.first();
		for (n = 0; n < fn.num(); n++)
		begin
			applyPair($sformatf("alu R2 %s", fn.name()),
				makeWord(OP_R2, 5'd1, 5'd2, {4'd0, fn, 5'd3}),
				makeWord(OP_R2, 5'd5, 5'd6, {4'hF, fn, 5'd9}), 2'b11);
			fn = fn.next();
		end
		// Function code 63 is not assigned
		applyPair("alu R2 unassigned", makeWord(OP_R2, 5'd1, 5'd2, {4'd0, 6'd63, 5'd3}),
			makeWord(OP_R2, 5'd1, 5'd2, {4'd0, 6'd63, 5'd3}), 2'b11);
		check("unassigned func isAlu", 1'b0, decoded[0].isAlu);
		check("unassigned func isIllegal", 1'b1, decoded[0].isIllegal);
	endtask

	// Every opcode again, so non-branches are seen to give BR_NONE
	task automatic memBranchTest();
		opcodeT op;
		int     n;
		op = op.first();
		for (n = 0; n < op.num(); n++)
		begin
			applyPair($sformatf("mem/branch %s", op.name()),
				makeWord(op, 5'd8, 5'd9, 15'h7ABC), makeWord(op, 5'd31, 5'd0, 15'h0001), 2'b11);
			op = op.next();
		end
	endtask

	task automatic regsImmTest();
		applyPair("writesRd rd zero", makeWord(OP_ADDI, 5'd0, 5'd1, 15'h0010),
			makeWord(OP_LDO, 5'd0, 5'd2, 15'h0020), 2'b11);
		check("rd zero ADDI writesRd", 1'b0, decoded[0].regs.writesRd);
		check("rd zero LDO writesRd", 1'b0, decoded[1].regs.writesRd);
		applyPair("writesRd rd nonzero", makeWord(OP_ADDI, 5'd9, 5'd1, 15'h0010),
			makeWord(OP_LDO, 5'd10, 5'd2, 15'h0020), 2'b11);
		check("rd nonzero ADDI writesRd", 1'b1, decoded[0].regs.writesRd);
		check("rd nonzero LDO writesRd", 1'b1, decoded[1].regs.writesRd);
		// Same negative field, once signed and once as a mask
		applyPair("imm negative", makeWord(OP_ADDI, 5'd4, 5'd5, 15'h7FF0),
			makeWord(OP_ANDI, 5'd4, 5'd5, 15'h7FF0), 2'b11);
		check("imm ADDI sign-extend", 32'hFFFF_FFF0, decoded[0].imm);
		check("imm ANDI zero-extend", 32'h0000_7FF0, decoded[1].imm);
	endtask

	task automatic stallTest();
		instrT   wa;
		instrT   wb;
		instrT   wc;
		instrT   wd;
		decodedT expA;
		decodedT expB;
		decodedT expC;
		decodedT expD;
		wa = makeWord(OP_STT, 5'd1, 5'd2, 15'h1111);
		wb = makeWord(OP_BNE, 5'd3, 5'd4, 15'h2222);
		wc = makeWord(OP_MOV, 5'd5, 5'd6, 15'h3333);
		wd = makeWord(OP_JSR, 5'd7, 5'd8, 15'h4444);
		expA = decodeModel(wa);
		expB = decodeModel(wb);
		expC = decodeModel(wc);
		expD = decodeModel(wd);
		applyPair("stall before", wa, wb, 2'b11);
		@(posedge clk);
		instr[0] <= wc;
		instr[1] <= wd;
		stall <= 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			check("stall hold decValid", 2'b11, decValid);
			check("stall hold lane0", expA, decoded[0]);
			check("stall hold lane1", expB, decoded[1]);
		end
		@(posedge clk);
		stall <= 1'b0;
		@(negedge clk);
		check("stall last held lane0", expA, decoded[0]);
		check("stall last held lane1", expB, decoded[1]);
		@(posedge clk);
		@(negedge clk);
		check("stall released lane0", expC, decoded[0]);
		check("stall released lane1", expD, decoded[1]);
	endtask

	task automatic laneValidTest();
		applyPair("lane1 idle", makeWord(OP_SUBFI, 5'd2, 5'd3, 15'h0005),
			makeWord(OP_ORI, 5'd4, 5'd5, 15'h0006), 2'b01);
		applyPair("lane0 idle", makeWord(OP_CMPI, 5'd2, 5'd3, 15'h0007),
			makeWord(OP_STB, 5'd4, 5'd5, 15'h0008), 2'b10);
	endtask

	// Random words on back to back cycles, each checked one cycle later
	task automatic pipelineTest();
		instrT wa;
		instrT wb;
		instrT pa;
		instrT pb;
		int    i;
		for (i = 0; i <= randCount; i++)
		begin
			@(posedge clk);
			if (i < randCount)
			begin
				wa = $random(seed);
				wb = $random(seed);
				instr[0] <= wa;
				instr[1] <= wb;
				instrValid <= 2'b11;
			end
			else
				instrValid <= 2'b00;
			if (i > 0)
			begin
				@(negedge clk);
				check($sformatf("pipeline %0d decValid", i), 2'b11, decValid);
				check($sformatf("pipeline %0d lane0", i), decodeModel(pa), decoded[0]);
				check($sformatf("pipeline %0d lane1", i), decodeModel(pb), decoded[1]);
			end
			pa = wa;
			pb = wb;
		end
	endtask

	// ================================================================
	// Main sequence and watchdog
	// ================================================================

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		assertFails = 0;
		clk = 1'b0;
		rstN = 1'b0;
		stall = 1'b0;
		instrValid = 2'b00;
		instr[0] = '0;
		instr[1] = '0;
		resetTest();
		aluTest();
		memBranchTest();
		regsImmTest();
		stallTest();
		laneValidTest();
		pipelineTest();
		// Lane assertions count their own failures
		assertFails = i_decodeTop.g_lane[0].i_slot.i_slotAssert.failCount +
			i_decodeTop.g_lane[1].i_slot.i_slotAssert.failCount;
		$display("Run complete with %0d checks, %0d errors and %0d assertion failures",
			checkCount, errorCount, assertFails);
		if ((errorCount == 0) && (assertFails == 0))
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		#((testCycles + marginCycles) * clkPeriod);
		$display("Timeout: the tests did not finish within %0d clock cycles",
			testCycles + marginCycles);
		$display("Something failed");
		$finish;
	end

endmodule

// File: vlog.f
common/decodePkg.sv
decode/decodeAlu.sv
decode/decodeMem.sv
decode/decodeBranch.sv
decode/decodeRegs.sv
decode/decodeImm.sv
decode/decodeSlot.sv
rtl/decodeTop.sv
bench/decodeSlot_assert.sv
bench/decodeTb.sv
